// ==== Makefile ====
SOURCES := $(wildcard rtl/*.sv tests/*.sv)

.PHONY: all run clean

all: run

obj_dir/Vtracking_tb: sim.f $(SOURCES)
	verilator --binary --timing --assert -Wno-fatal -f sim.f --top-module tracking_tb \
		-Mdir obj_dir -o Vtracking_tb

run: obj_dir/Vtracking_tb
	./obj_dir/Vtracking_tb | tee /dev/stderr | grep -q "Simulation PASSED"

clean:
	rm -rf obj_dir

// ==== rtl/blob_record_pkg.sv ====
`default_nettype none

package blob_record_pkg;

	localparam int ADDR_W = 18;
	localparam int WORD_W = 32;

	// Each blob record is three consecutive words from the table base
	localparam int RECORD_WORDS  = 3;
	localparam int COLOR_WORD    = 0;
	localparam int SHAPE_WORD    = 1;
	localparam int CENTROID_WORD = 2;

	localparam int MEM_READ_LATENCY = 2; // Port register plus registered RAM

	typedef logic [ADDR_W-1:0] mem_addr_t;
	typedef logic [WORD_W-1:0] mem_word_t;
	typedef logic [15:0]       metric_t;
	typedef logic [15:0]       blob_idx_t;

	typedef struct packed {
		logic [23:0] reserved;
		logic [7:0]  color;    // 0 is unrecognised, else colour plus one
	} color_word_t;

	typedef struct packed {
		logic [7:0]  reserved;
		logic [7:0]  top_row;
		logic [15:0] size;
	} shape_word_t;

	typedef struct packed {
		logic [7:0]  x;
		logic [7:0]  y;
		logic [15:0] size;
	} centroid_t;

endpackage

`default_nettype wire

// ==== rtl/blob_scanner.sv ====
`timescale 1ns/1ps
`default_nettype none

module blob_scanner
	import tracking_cfg_pkg::*, blob_record_pkg::*;
#(
	parameter int unsigned TABLE_BASE = 200000
) (
	input  wire            crystal_clk_div_by_two,
	input  wire            arst_n,
	input  wire            pause,
	input  wire            scan_start,
	input  wire            find_highest,
	input  wire blob_idx_t blob_count,
	input  wire [7:0]      minimum_blob_size,
	output logic           scan_done,
	mem_port_if.requester  mem,
	rank_update_if.driver  upd
);

	typedef enum logic [1:0] {S_IDLE, S_COLOR, S_SHAPE} scan_state_t;

	localparam mem_addr_t BASE_ADDR = mem_addr_t'(TABLE_BASE);

	scan_state_t state;
	blob_idx_t   rec_idx;
	mem_addr_t   rec_addr;   // Word 0 of the current record
	logic [1:0]  wait_cnt;
	color_word_t color_word;
	shape_word_t shape_word;
	metric_t     metric;
	logic        sample;
	logic        color_ok;
	logic        rec_end;
	logic        last_rec;

	assign color_word = color_word_t'(mem.data_read);
	assign shape_word = shape_word_t'(mem.data_read);
	assign sample     = (wait_cnt == MEM_READ_LATENCY);
	assign color_ok   = (color_word.color != '0) && (color_word.color <= NUM_COLORS);
	assign rec_end    = sample && ((state == S_SHAPE) || (state == S_COLOR && !color_ok));
	assign last_rec   = (rec_idx == blob_count - 1'b1);

	assign mem.wren       = 1'b0; // Table walk never writes
	assign mem.data_write = '0;

	always_comb begin
		if (find_highest) begin
			metric = (shape_word.top_row > HEIGHT_LIMIT) ? '0 : metric_t'(shape_word.top_row);
		end else begin
			metric = shape_word.size;
		end
	end

	always_ff @(posedge crystal_clk_div_by_two or negedge arst_n) begin
		if (!arst_n) begin
			state       <= S_IDLE;
			rec_idx     <= '0;
			rec_addr    <= '0;
			wait_cnt    <= '0;
			scan_done   <= 1'b0;
			mem.address <= '0;
			upd.valid   <= 1'b0;
			upd.color   <= '0;
			upd.metric  <= '0;
			upd.index   <= '0;
		end else if (!pause) begin
			scan_done <= 1'b0;
			upd.valid <= 1'b0;
			if (scan_start) begin
				rec_idx     <= '0;
				rec_addr    <= BASE_ADDR;
				mem.address <= BASE_ADDR + mem_addr_t'(COLOR_WORD);
				wait_cnt    <= '0;
				if (blob_count == '0) begin
					scan_done <= 1'b1; // Empty table
					state     <= S_IDLE;
				end else begin
					state <= S_COLOR;
				end
			end else begin
				case (state)
				S_COLOR: begin
					wait_cnt <= sample ? '0 : wait_cnt + 1'b1;
					if (sample && color_ok) begin
						upd.color   <= color_idx_t'(color_word.color - 1'b1);
						mem.address <= rec_addr + mem_addr_t'(SHAPE_WORD);
						state       <= S_SHAPE;
					end
				end
				S_SHAPE: begin
					wait_cnt <= sample ? '0 : wait_cnt + 1'b1;
					if (sample && metric > metric_t'(minimum_blob_size)) begin
						upd.valid  <= 1'b1;
						upd.metric <= metric;
						upd.index  <= rec_idx;
					end
				end
				default: state <= S_IDLE;
				endcase

				// Step to the next record or finish the walk
				if (rec_end) begin
					if (last_rec) begin
						scan_done <= 1'b1;
						state     <= S_IDLE;
					end else begin
						rec_idx     <= rec_idx + 1'b1;
						rec_addr    <= rec_addr + mem_addr_t'(RECORD_WORDS);
						mem.address <= rec_addr + mem_addr_t'(RECORD_WORDS + COLOR_WORD);
						state       <= S_COLOR;
					end
				end
			end
		end
	end

endmodule

`default_nettype wire

// ==== rtl/centroid_extractor.sv ====
`timescale 1ns/1ps
`default_nettype none

module centroid_extractor
	import tracking_cfg_pkg::*, blob_record_pkg::*;
#(
	parameter int unsigned TABLE_BASE = 200000
) (
	input  wire                      crystal_clk_div_by_two,
	input  wire                      arst_n,
	input  wire                      pause,
	input  wire                      extract_start,
	input  wire                      two_color_mode,
	output logic                     extract_done,
	output logic [NUM_SLOTS*8-1:0]   x_centroids_array,
	output logic [NUM_SLOTS*8-1:0]   y_centroids_array,
	output logic [NUM_SLOTS*16-1:0]  s_centroids_array,
	mem_port_if.requester            mem,
	rank_query_if.requester          qry
);

	typedef enum logic [1:0] {E_IDLE, E_LOOKUP, E_READ, E_WRITE} ext_state_t;

	localparam mem_addr_t BASE_ADDR = mem_addr_t'(TABLE_BASE);

	ext_state_t state;
	logic [2:0] slot;
	logic [1:0] wait_cnt;
	centroid_t  word;
	centroid_t  cleared;  // Word with its size consumed

	assign word    = centroid_t'(mem.data_read);
	assign cleared = '{x: word.x, y: word.y, size: '0};

	// Two-colour mode lists ranks 0 to 2 of colour 0, then of colour 1
	always_comb begin
		if (two_color_mode) begin
			qry.color = (slot < NUM_RANKS) ? color_idx_t'(0) : color_idx_t'(1);
			qry.rank  = (slot < NUM_RANKS) ? rank_idx_t'(slot) : rank_idx_t'(slot - NUM_RANKS);
		end else begin
			qry.color = color_idx_t'(slot);
			qry.rank  = '0;
		end
	end

	always_ff @(posedge crystal_clk_div_by_two or negedge arst_n) begin
		if (!arst_n) begin
			state             <= E_IDLE;
			slot              <= '0;
			wait_cnt          <= '0;
			extract_done      <= 1'b0;
			mem.address       <= '0;
			mem.wren          <= 1'b0;
			mem.data_write    <= '0;
			x_centroids_array <= '0;
			y_centroids_array <= '0;
			s_centroids_array <= '0;
		end else if (!pause) begin
			extract_done <= 1'b0;
			if (extract_start) begin
				state             <= E_LOOKUP;
				slot              <= '0;
				mem.wren          <= 1'b0;
				x_centroids_array <= '0;
				y_centroids_array <= '0;
				s_centroids_array <= '0;
			end else begin
				case (state)
				E_LOOKUP: begin
					mem.address <= BASE_ADDR + mem_addr_t'(qry.index) * mem_addr_t'(RECORD_WORDS)
						+ mem_addr_t'(CENTROID_WORD);
					wait_cnt    <= '0;
					state       <= E_READ;
				end
				E_READ: begin
					wait_cnt <= wait_cnt + 1'b1;
					if (wait_cnt == MEM_READ_LATENCY) begin
						if (qry.metric != '0) begin // Empty slot keeps zeros
							x_centroids_array[slot*8 +: 8]   <= word.x;
							y_centroids_array[slot*8 +: 8]   <= word.y;
							s_centroids_array[slot*16 +: 16] <= word.size;
							mem.data_write                   <= cleared;
							mem.wren                         <= 1'b1;
						end
						state <= E_WRITE;
					end
				end
				E_WRITE: begin
					mem.wren <= 1'b0;
					if (slot == 3'(NUM_SLOTS - 1)) begin
						extract_done <= 1'b1;
						state        <= E_IDLE;
					end else begin
						slot  <= slot + 1'b1;
						state <= E_LOOKUP;
					end
				end
				default: state <= E_IDLE;
				endcase
			end
		end
	end

endmodule

`default_nettype wire

// ==== rtl/rank_table.sv ====
`timescale 1ns/1ps
`default_nettype none

module rank_table
	import tracking_cfg_pkg::*, blob_record_pkg::*;
(
	input  wire              crystal_clk_div_by_two,
	input  wire              arst_n,
	input  wire              pause,
	rank_update_if.receiver  upd,
	rank_query_if.responder  qry
);

	metric_t   rank_metric [NUM_COLORS][NUM_RANKS]; // Zero marks an empty entry
	blob_idx_t rank_index  [NUM_COLORS][NUM_RANKS];

	logic [NUM_RANKS-1:0] beats;    // Candidate strictly above this rank
	logic [NUM_RANKS-1:0] shift_dn; // Entry above moves into this rank

	// Ranks are kept in descending order, so beats is a run of ones from the bottom
	always_comb begin
		shift_dn = '0;
		for (int r = 0; r < NUM_RANKS; r++) begin
			beats[r] = (upd.metric > rank_metric[upd.color][r]);
		end
		for (int r = 1; r < NUM_RANKS; r++) begin
			shift_dn[r] = beats[r-1];
		end
	end

	assign qry.metric = rank_metric[qry.color][qry.rank];
	assign qry.index  = rank_index[qry.color][qry.rank];

	always_ff @(posedge crystal_clk_div_by_two or negedge arst_n) begin
		if (!arst_n) begin
			for (int c = 0; c < NUM_COLORS; c++) begin
				for (int r = 0; r < NUM_RANKS; r++) begin
					rank_metric[c][r] <= '0;
					rank_index[c][r]  <= '0;
				end
			end
		end else if (!pause) begin
			if (upd.clear) begin
				for (int c = 0; c < NUM_COLORS; c++) begin
					for (int r = 0; r < NUM_RANKS; r++) begin
						rank_metric[c][r] <= '0;
						rank_index[c][r]  <= '0;
					end
				end
			end else if (upd.valid) begin
				for (int r = 1; r < NUM_RANKS; r++) begin
					if (shift_dn[r]) begin
						rank_metric[upd.color][r] <= rank_metric[upd.color][r-1];
						rank_index[upd.color][r]  <= rank_index[upd.color][r-1];
					end
				end
				for (int r = 0; r < NUM_RANKS; r++) begin
					if (beats[r] && !shift_dn[r]) begin // Highest rank it beats
						rank_metric[upd.color][r] <= upd.metric;
						rank_index[upd.color][r]  <= upd.index;
					end
				end
			end
		end
	end

endmodule

`default_nettype wire

// ==== rtl/tracking_cfg_pkg.sv ====
`default_nettype none

package tracking_cfg_pkg;

	localparam int NUM_COLORS     = 6;   // Tracked colours
	localparam int NUM_RANKS      = 3;   // Blobs kept per colour
	localparam int NUM_SLOTS      = 6;   // Centroids produced per run
	localparam int HEIGHT_LIMIT   = 120; // Highest valid top row
	localparam int ENABLE_QUALIFY = 2;   // Unpaused enable cycles before a run

	typedef logic [2:0] color_idx_t;
	typedef logic [1:0] rank_idx_t;

endpackage

`default_nettype wire

// ==== rtl/tracking_ifs.sv ====
`timescale 1ns/1ps
`default_nettype none

// One memory requester, forwarded to the pins by the sequencer
interface mem_port_if
	import blob_record_pkg::*;
();
	mem_addr_t address;
	logic      wren;
	mem_word_t data_write;
	mem_word_t data_read;

	modport requester (output address, wren, data_write, input data_read);
	modport arbiter (input address, wren, data_write, output data_read);
endinterface

interface rank_update_if
	import tracking_cfg_pkg::*, blob_record_pkg::*;
();
	logic       clear;
	logic       valid;  // One strobe per candidate
	color_idx_t color;
	metric_t    metric;
	blob_idx_t  index;

	modport driver (output valid, color, metric, index);
	modport clearer (output clear);
	modport receiver (input clear, valid, color, metric, index);
endinterface

// Lookup of one table entry, answered in the same cycle
interface rank_query_if
	import tracking_cfg_pkg::*, blob_record_pkg::*;
();
	color_idx_t color;
	rank_idx_t  rank;
	metric_t    metric;
	blob_idx_t  index;

	modport requester (output color, rank, input metric, index);
	modport responder (input color, rank, output metric, index);
endinterface

`default_nettype wire

// ==== rtl/tracking_sequencer.sv ====
`timescale 1ns/1ps
`default_nettype none

module tracking_sequencer
	import tracking_cfg_pkg::*, blob_record_pkg::*;
(
	input  wire              crystal_clk_div_by_two,
	input  wire              arst_n,
	input  wire              pause,
	input  wire              enable_tracking_output,
	input  wire              scan_done,
	input  wire              extract_done,
	input  wire mem_word_t   data_read,
	output logic             scan_start,
	output logic             extract_start,
	output logic             tracking_output_done,
	output logic             wren,
	output mem_addr_t        address,
	output mem_word_t        data_write,
	mem_port_if.arbiter      scan_mem,
	mem_port_if.arbiter      extract_mem,
	rank_update_if.clearer   upd
);

	typedef enum logic [2:0] {P_IDLE, P_CLEAR, P_SCAN, P_EXTRACT, P_DONE} phase_t;

	localparam int QUAL_W = $clog2(ENABLE_QUALIFY + 1);

	phase_t            phase;
	logic [QUAL_W-1:0] qual_cnt;  // Saturates once qualified
	logic              qualified;

	assign qualified            = (qual_cnt >= QUAL_W'(ENABLE_QUALIFY - 1));
	assign tracking_output_done = (phase == P_DONE);
	assign scan_mem.data_read    = data_read;
	assign extract_mem.data_read = data_read;

	always_ff @(posedge crystal_clk_div_by_two or negedge arst_n) begin
		if (!arst_n) begin
			phase         <= P_IDLE;
			qual_cnt      <= '0;
			upd.clear     <= 1'b0;
			scan_start    <= 1'b0;
			extract_start <= 1'b0;
			wren          <= 1'b0;
			address       <= '0;
			data_write    <= '0;
		end else if (!pause) begin
			upd.clear     <= 1'b0;
			scan_start    <= 1'b0;
			extract_start <= 1'b0;
			if (!enable_tracking_output) begin
				phase      <= P_IDLE; // Abandon any run and release the memory
				qual_cnt   <= '0;
				wren       <= 1'b0;
				address    <= '0;
				data_write <= '0;
			end else begin
				if (!qualified) begin
					qual_cnt <= qual_cnt + 1'b1;
				end
				case (phase)
				P_IDLE: begin
					if (qualified) begin
						upd.clear <= 1'b1;
						phase     <= P_CLEAR;
					end
				end
				P_CLEAR: begin
					scan_start <= 1'b1;
					phase      <= P_SCAN;
				end
				P_SCAN: begin
					if (scan_done) begin
						extract_start <= 1'b1;
						phase         <= P_EXTRACT;
					end
				end
				P_EXTRACT: begin
					if (extract_done) begin
						phase <= P_DONE;
					end
				end
				P_DONE:  phase <= P_DONE; // Held until the enable drops
				default: phase <= P_IDLE;
				endcase

				// Port register, one cycle behind the active requester
				case (phase)
				P_SCAN: begin
					wren       <= scan_mem.wren;
					address    <= scan_mem.address;
					data_write <= scan_mem.data_write;
				end
				P_EXTRACT: begin
					wren       <= extract_mem.wren;
					address    <= extract_mem.address;
					data_write <= extract_mem.data_write;
				end
				default: begin
					wren       <= 1'b0;
					address    <= '0;
					data_write <= '0;
				end
				endcase
			end
		end
	end

endmodule

`default_nettype wire

// ==== rtl/tracking_top.sv ====
`timescale 1ns/1ps
`default_nettype none

module tracking_top
	import tracking_cfg_pkg::*, blob_record_pkg::*;
#(
	parameter int unsigned TABLE_BASE = 200000  // Address of record 0
) (
	input  wire                      crystal_clk_div_by_two,
	input  wire                      arst_n,
	input  wire                      pause,
	input  wire                      enable_tracking_output,
	input  wire                      find_highest,
	input  wire                      two_color_mode,
	input  wire blob_idx_t           blob_count,
	input  wire [7:0]                minimum_blob_size,
	input  wire mem_word_t           data_read,
	output logic                     wren,
	output mem_word_t                data_write,
	output mem_addr_t                address,
	output logic [NUM_SLOTS*8-1:0]   x_centroids_array,
	output logic [NUM_SLOTS*8-1:0]   y_centroids_array,
	output logic [NUM_SLOTS*16-1:0]  s_centroids_array,
	output logic                     tracking_output_done
);

	logic scan_start;
	logic scan_done;
	logic extract_start;
	logic extract_done;

	mem_port_if    scan_mem ();
	mem_port_if    extract_mem ();
	rank_update_if rank_upd ();
	rank_query_if  rank_qry ();

	tracking_sequencer sequencer_i (
		.crystal_clk_div_by_two (crystal_clk_div_by_two),
		.arst_n                 (arst_n),
		.pause                  (pause),
		.enable_tracking_output (enable_tracking_output),
		.scan_done              (scan_done),
		.extract_done           (extract_done),
		.data_read              (data_read),
		.scan_start             (scan_start),
		.extract_start          (extract_start),
		.tracking_output_done   (tracking_output_done),
		.wren                   (wren),
		.address                (address),
		.data_write             (data_write),
		.scan_mem               (scan_mem),
		.extract_mem            (extract_mem),
		.upd                    (rank_upd)
	);

	blob_scanner #(
		.TABLE_BASE (TABLE_BASE)
	) scanner_i (
		.crystal_clk_div_by_two (crystal_clk_div_by_two),
		.arst_n                 (arst_n),
		.pause                  (pause),
		.scan_start             (scan_start),
		.find_highest           (find_highest),
		.blob_count             (blob_count),
		.minimum_blob_size      (minimum_blob_size),
		.scan_done              (scan_done),
		.mem                    (scan_mem),
		.upd                    (rank_upd)
	);

	rank_table rank_table_i (
		.crystal_clk_div_by_two (crystal_clk_div_by_two),
		.arst_n                 (arst_n),
		.pause                  (pause),
		.upd                    (rank_upd),
		.qry                    (rank_qry)
	);

	centroid_extractor #(
		.TABLE_BASE (TABLE_BASE)
	) extractor_i (
		.crystal_clk_div_by_two (crystal_clk_div_by_two),
		.arst_n                 (arst_n),
		.pause                  (pause),
		.extract_start          (extract_start),
		.two_color_mode         (two_color_mode),
		.extract_done           (extract_done),
		.x_centroids_array      (x_centroids_array),
		.y_centroids_array      (y_centroids_array),
		.s_centroids_array      (s_centroids_array),
		.mem                    (extract_mem),
		.qry                    (rank_qry)
	);

endmodule

`default_nettype wire

// ==== sim.f ====
rtl/tracking_cfg_pkg.sv
rtl/blob_record_pkg.sv
rtl/tracking_ifs.sv
rtl/blob_scanner.sv
rtl/rank_table.sv
rtl/centroid_extractor.sv
rtl/tracking_sequencer.sv
rtl/tracking_top.sv
tests/tracking_props.sv
tests/tracking_tb.sv

// ==== tests/tracking_props.sv ====
`timescale 1ns/1ps
`default_nettype none

module tracking_props
	import blob_record_pkg::*;
(
	input wire            clk,
	input wire            arst_n,
	input wire            pause,
	input wire            enable,
	input wire            wren,
	input wire mem_addr_t address,
	input wire            done
);

	// Memory stays quiet once the run has finished
	done_no_write: assert property (@(posedge clk) disable iff (!arst_n)
		done |-> !wren)
		else $error("wren high while tracking_output_done is set");

	// Enable low on an unpaused cycle releases the port
	enable_low_clears: assert property (@(posedge clk) disable iff (!arst_n)
		(!pause && !enable) |=> (!done && !wren && address == '0))
		else $error("done, wren or address not cleared after enable dropped");

	reset_no_write: assert property (@(posedge clk) $rose(arst_n) |-> !wren)
		else $error("wren high as reset released");

endmodule

bind tracking_top tracking_props props_i (
	.clk     (crystal_clk_div_by_two),
	.arst_n  (arst_n),
	.pause   (pause),
	.enable  (enable_tracking_output),
	.wren    (wren),
	.address (address),
	.done    (tracking_output_done)
);

`default_nettype wire

// ==== tests/tracking_tb.sv ====
`timescale 1ns/1ps
`default_nettype none

module tracking_tb
	import tracking_cfg_pkg::*, blob_record_pkg::*;
();

	localparam int CLK_PERIOD  = 100;
	localparam int BASE        = 64;   // Table base given to the DUT
	localparam int NUM_SCEN    = 4;
	localparam int MAX_REC     = 8;
	localparam int RUN_LIMIT   = 3000; // Cycles allowed per run
	localparam int WATCHDOG_NS = (NUM_SCEN * (RUN_LIMIT + 60) + 20) * CLK_PERIOD;

	logic                  crystal_clk_div_by_two;
	logic                  arst_n;
	logic                  pause;
	logic                  enable_tracking_output;
	logic                  find_highest;
	logic                  two_color_mode;
	blob_idx_t             blob_count;
	logic [7:0]            minimum_blob_size;
	mem_word_t             data_read;
	logic                  wren;
	mem_word_t             data_write;
	mem_addr_t             address;
	logic [NUM_SLOTS*8-1:0]  x_centroids_array;
	logic [NUM_SLOTS*8-1:0]  y_centroids_array;
	logic [NUM_SLOTS*16-1:0] s_centroids_array;
	logic                  tracking_output_done;

	mem_word_t mem_array [1024];
	mem_word_t exp_mem   [1024];
	integer    seed = 32'h7163;
	int        errors = 0;
	int        checks = 0;

	// Scenario table
	int         sc_count    [NUM_SCEN];
	logic       sc_highest  [NUM_SCEN];
	logic       sc_two      [NUM_SCEN];
	logic [7:0] sc_min      [NUM_SCEN];
	int         sc_pause_at [NUM_SCEN]; // Zero means no pause
	logic [7:0]  rec_color  [NUM_SCEN][MAX_REC];
	logic [15:0] rec_size   [NUM_SCEN][MAX_REC];
	logic [7:0]  rec_row    [NUM_SCEN][MAX_REC];
	int          exp_rec    [NUM_SCEN][NUM_SLOTS]; // -1 is an empty slot

	tracking_top #(
		.TABLE_BASE (BASE)
	) dut_i (
		.crystal_clk_div_by_two (crystal_clk_div_by_two),
		.arst_n                 (arst_n),
		.pause                  (pause),
		.enable_tracking_output (enable_tracking_output),
		.find_highest           (find_highest),
		.two_color_mode         (two_color_mode),
		.blob_count             (blob_count),
		.minimum_blob_size      (minimum_blob_size),
		.data_read              (data_read),
		.wren                   (wren),
		.data_write             (data_write),
		.address                (address),
		.x_centroids_array      (x_centroids_array),
		.y_centroids_array      (y_centroids_array),
		.s_centroids_array      (s_centroids_array),
		.tracking_output_done   (tracking_output_done)
	);

	initial begin
		crystal_clk_div_by_two = 1'b0;
		forever #(CLK_PERIOD / 2) crystal_clk_div_by_two = ~crystal_clk_div_by_two;
	end

	// Registered RAM, read returns the old word
	always @(posedge crystal_clk_div_by_two) begin
		data_read <= mem_array[address[9:0]];
		if (wren) begin
			mem_array[address[9:0]] = data_write;
		end
	end

	initial begin
		#(WATCHDOG_NS);
		$display("Watchdog expired, the run did not finish in time");
		$display("Simulation FAILED");
		$finish;
	end

	function automatic mem_word_t fill_word(input logic [9:0] a);
		return {6'h2b, a, 6'h14, a};
	endfunction

	task automatic check(input string name, input logic [95:0] got, input logic [95:0] exp);
		checks++;
		if (got !== exp) begin
			errors++;
			$display("MISMATCH %s: got %0h, expected %0h", name, got, exp);
		end
	endtask

	task automatic set_scen(input int s, input int count, input logic highest,
		input logic two, input logic [7:0] min_size, input int pause_at);
		sc_count[s]    = count;
		sc_highest[s]  = highest;
		sc_two[s]      = two;
		sc_min[s]      = min_size;
		sc_pause_at[s] = pause_at;
	endtask

	task automatic set_rec(input int s, input int r, input logic [7:0] color,
		input logic [15:0] size, input logic [7:0] row);
		rec_color[s][r] = color;
		rec_size[s][r]  = size;
		rec_row[s][r]   = row;
	endtask

	task automatic set_slots(input int s, input int a, input int b, input int c,
		input int d, input int e, input int f);
		exp_rec[s][0] = a;
		exp_rec[s][1] = b;
		exp_rec[s][2] = c;
		exp_rec[s][3] = d;
		exp_rec[s][4] = e;
		exp_rec[s][5] = f;
	endtask

	task automatic load_memory(input int s);
		int        a;
		mem_word_t w0;
		mem_word_t w1;
		mem_word_t w2;
		for (int i = 0; i < 1024; i++) begin
			mem_array[i] = fill_word(10'(i));
		end
		for (int r = 0; r < sc_count[s]; r++) begin
			a = BASE + RECORD_WORDS * r;
			if (rec_color[s][r] == 8'h00) begin // Distractor
				w0 = $random(seed);
				w0[7:0] = 8'h00;
				w1 = $random(seed);
				w2 = $random(seed);
			end else begin
				w0 = {24'h0, rec_color[s][r]};
				w1 = {8'h0, rec_row[s][r], rec_size[s][r]};
				w2 = {8'(16 * s + r + 1), 8'(8'h80 + 8 * s + r), 16'(256 * (s + 1) + r + 1)};
			end
			mem_array[a]     = w0;
			mem_array[a + 1] = w1;
			mem_array[a + 2] = w2;
		end
		for (int i = 0; i < 1024; i++) begin
			exp_mem[i] = mem_array[i];
		end
	endtask

	task automatic run_scenario(input int s);
		int                      cyc;
		int                      a;
		int                      errors_before;
		mem_word_t               cw;
		mem_addr_t               held_addr;
		logic                    held_wren;
		mem_word_t               held_data;
		logic [NUM_SLOTS*8-1:0]  ex_x;
		logic [NUM_SLOTS*8-1:0]  ex_y;
		logic [NUM_SLOTS*16-1:0] ex_s;
		errors_before = errors;
		@(negedge crystal_clk_div_by_two);
		enable_tracking_output = 1'b0;
		pause = 1'b0;
		repeat (2) @(negedge crystal_clk_div_by_two);
		load_memory(s);
		ex_x = '0;
		ex_y = '0;
		ex_s = '0;
		for (int k = 0; k < NUM_SLOTS; k++) begin
			if (exp_rec[s][k] >= 0) begin
				a = BASE + RECORD_WORDS * exp_rec[s][k] + 2;
				cw = mem_array[a];
				ex_x[k*8 +: 8]   = cw[31:24];
				ex_y[k*8 +: 8]   = cw[23:16];
				ex_s[k*16 +: 16] = cw[15:0];
				exp_mem[a] = {cw[31:16], 16'h0000}; // Size consumed
			end
		end
		find_highest           = sc_highest[s];
		two_color_mode         = sc_two[s];
		minimum_blob_size      = sc_min[s];
		blob_count             = blob_idx_t'(sc_count[s]);
		enable_tracking_output = 1'b1;
		cyc = 0;
		while (!tracking_output_done && cyc < RUN_LIMIT) begin
			@(negedge crystal_clk_div_by_two);
			cyc++;
			if (cyc == sc_pause_at[s]) begin
				held_addr = address;
				held_wren = wren;
				held_data = data_write;
				pause = 1'b1;
				repeat (10) begin
					@(negedge crystal_clk_div_by_two);
					check("address", address, held_addr); // Frozen while paused
					check("wren", wren, held_wren);
					check("data_write", data_write, held_data);
				end
				pause = 1'b0;
			end
		end
		if (!tracking_output_done) begin
			errors++;
			$display("Test %0d: tracking_output_done never rose within %0d cycles", s, RUN_LIMIT);
		end
		repeat (5) @(negedge crystal_clk_div_by_two);
		check("tracking_output_done", tracking_output_done, 1);
		check("x_centroids_array", x_centroids_array, ex_x);
		check("y_centroids_array", y_centroids_array, ex_y);
		check("s_centroids_array", s_centroids_array, ex_s);
		for (int i = BASE; i < BASE + RECORD_WORDS * MAX_REC + 4; i++) begin
			check($sformatf("mem[%0d]", i), mem_array[i], exp_mem[i]);
		end
		enable_tracking_output = 1'b0;
		@(negedge crystal_clk_div_by_two);
		check("tracking_output_done", tracking_output_done, 0);
		check("wren", wren, 0);
		check("address", address, 0);
		check("data_write", data_write, 0);
		$display("Test %0d finished after %0d cycles with %0d errors", s, cyc,
			errors - errors_before);
	endtask

	initial begin
		arst_n                 = 1'b0;
		pause                  = 1'b0;
		enable_tracking_output = 1'b0;
		find_highest           = 1'b0;
		two_color_mode         = 1'b0;
		blob_count             = '0;
		minimum_blob_size      = '0;
		data_read              <= '0;

		// Biggest, normal mode
		set_scen(0, 7, 1'b0, 1'b0, 8'd10, 0);
		set_rec(0, 0, 8'd1, 16'd50, 8'd10);
		set_rec(0, 1, 8'd0, 16'd0, 8'd0);
		set_rec(0, 2, 8'd1, 16'd80, 8'd20);
		set_rec(0, 3, 8'd4, 16'd10, 8'd30);  // At the minimum, ignored
		set_rec(0, 4, 8'd3, 16'd11, 8'd40);
		set_rec(0, 5, 8'd6, 16'd200, 8'd50);
		set_rec(0, 6, 8'd2, 16'd5, 8'd60);
		set_slots(0, 2, -1, 4, -1, -1, 5);
		// Highest mode with a pause mid-run
		set_scen(1, 5, 1'b1, 1'b0, 8'd5, 15);
		set_rec(1, 0, 8'd1, 16'd1000, 8'd40);
		set_rec(1, 1, 8'd1, 16'd1, 8'd121); // Above the height bound
		set_rec(1, 2, 8'd1, 16'd2, 8'd100);
		set_rec(1, 3, 8'd2, 16'd3, 8'd120);
		set_rec(1, 4, 8'd0, 16'd0, 8'd0);
		set_slots(1, 2, 3, -1, -1, -1, -1);
		// Two-colour mode with a tie
		set_scen(2, 6, 1'b0, 1'b1, 8'd0, 0);
		set_rec(2, 0, 8'd1, 16'd30, 8'd1);
		set_rec(2, 1, 8'd1, 16'd30, 8'd2);
		set_rec(2, 2, 8'd1, 16'd40, 8'd3);
		set_rec(2, 3, 8'd1, 16'd20, 8'd4);
		set_rec(2, 4, 8'd2, 16'd9, 8'd5);
		set_rec(2, 5, 8'd4, 16'd99, 8'd6);
		set_slots(2, 2, 0, 1, 4, -1, -1);
		set_scen(3, 3, 1'b0, 1'b0, 8'd3, 0);
		set_rec(3, 0, 8'd5, 16'd7, 8'd0);
		set_rec(3, 1, 8'd4, 16'd300, 8'd0);
		set_rec(3, 2, 8'd0, 16'd0, 8'd0);
		set_slots(3, -1, -1, -1, 1, 0, -1);

		repeat (8) @(posedge crystal_clk_div_by_two);
		@(negedge crystal_clk_div_by_two);
		arst_n = 1'b1;
		check("wren", wren, 0);

		for (int s = 0; s < NUM_SCEN; s++) begin
			run_scenario(s);
		end

		$display("Tests run: %0d, checks: %0d, errors: %0d", NUM_SCEN, checks, errors);
		if (errors == 0) begin
			$display("Simulation PASSED");
		end else begin
			$display("Simulation FAILED");
		end
		$finish;
	end

endmodule

`default_nettype wire
